/* source/hist_settings.svh */
`ifndef HIST_SETTINGS_SVH
`define HIST_SETTINGS_SVH

// bin index width, 16 bins per pixel.
`define HIST_BIN_BITS 4
// pixel index width, 4 pixels.
`define HIST_PIX_BITS 2
// count width, saturates at 63.
`define HIST_COUNT_W 6
`define HIST_ACQS 3     // acquisitions summed per frame.
`define HIST_CREDITS 4  // words the consumer can buffer.

`define HIST_ADDR_W (`HIST_PIX_BITS + `HIST_BIN_BITS)

// event payload below the kind bit, one spare bit keeps padding in both views.
`define HIST_EV_PAY_W (((`HIST_BIN_BITS > `HIST_PIX_BITS + 1) ? \
                        `HIST_BIN_BITS : `HIST_PIX_BITS + 1) + 1)

`endif

/* source/hist_pkg.sv */
package hist_pkg;

`include "hist_settings.svh"

    typedef enum logic {
        EV_HIT    = 1'b0,
        EV_MARKER = 1'b1
    } event_kind_t;

    typedef struct packed {
        event_kind_t                                  kind;
        logic [`HIST_EV_PAY_W-`HIST_BIN_BITS-1:0]     pad;
        logic [`HIST_BIN_BITS-1:0]                    bin;
    } hit_view_t;

    typedef struct packed {
        event_kind_t                                  kind;
        logic [`HIST_EV_PAY_W-`HIST_PIX_BITS-2:0]     pad;
        logic                                         eoa;   // end of acquisition.
        logic [`HIST_PIX_BITS-1:0]                    pixel;
    } marker_view_t;

    // same word, seen as a hit by the accumulator and as a marker by the FSM.
    typedef union packed {
        hit_view_t    hit;
        marker_view_t marker;
    } event_word_t;

    typedef struct packed {
        logic [`HIST_PIX_BITS-1:0] pixel;
        logic [`HIST_BIN_BITS-1:0] bin;
    } bin_addr_t;

    typedef logic [`HIST_COUNT_W-1:0] bin_count_t;

endpackage

/* source/bin_mem_if.sv */
`timescale 1ns/1ps

interface bin_mem_if;
    import hist_pkg::*;

    logic       rd_en;
    bin_addr_t  rd_addr;
    bin_count_t rd_data;   // valid one cycle after rd_en.
    logic       wr_en;
    bin_addr_t  wr_addr;
    bin_count_t wr_data;

    modport client (
        output rd_en,
        output rd_addr,
        input  rd_data,
        output wr_en,
        output wr_addr,
        output wr_data
    );

    modport memory (
        input  rd_en,
        input  rd_addr,
        output rd_data,
        input  wr_en,
        input  wr_addr,
        input  wr_data
    );

endinterface

/* source/hist_ctrl.sv */
`timescale 1ns/1ps
`include "hist_settings.svh"

module hist_ctrl (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      ev_valid,
    input  hist_pkg::event_word_t     ev_word,
    input  logic                      clear_done,
    input  logic                      acc_busy,
    input  logic                      ro_done,
    output logic                      accepting,
    output logic [`HIST_PIX_BITS-1:0] cur_pixel,
    output logic                      ro_select,
    output logic                      ro_start,
    output logic                      frame_done
);
    import hist_pkg::*;

    localparam logic [1:0] ST_CLEAR   = 2'd0;  // sweep running, or frame just ended.
    localparam logic [1:0] ST_ACCUM   = 2'd1;
    localparam logic [1:0] ST_DRAIN   = 2'd2;  // wait for the accumulator pipeline.
    localparam logic [1:0] ST_READOUT = 2'd3;

    logic [1:0]                        state;
    logic [$clog2(`HIST_ACQS + 1)-1:0] acq_cnt;
    logic                              marker_taken;

    assign marker_taken = ev_valid && accepting && (ev_word.marker.kind == EV_MARKER);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= ST_CLEAR;
            acq_cnt    <= '0;
            accepting  <= 1'b0;
            cur_pixel  <= '0;
            ro_select  <= 1'b0;
            ro_start   <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            ro_start   <= 1'b0;
            frame_done <= 1'b0;
            case (state)
                ST_CLEAR: begin
                    if (clear_done) begin
                        accepting <= 1'b1;
                        state     <= ST_ACCUM;
                    end
                end
                ST_ACCUM: begin
                    if (marker_taken) begin
                        cur_pixel <= ev_word.marker.pixel;
                        if (ev_word.marker.eoa) begin
                            if (acq_cnt == `HIST_ACQS - 1) begin
                                acq_cnt   <= '0;
                                accepting <= 1'b0;  // last acquisition of the frame.
                                state     <= ST_DRAIN;
                            end else begin
                                acq_cnt <= acq_cnt + 1'b1;
                            end
                        end
                    end
                end
                ST_DRAIN: begin
                    if (!acc_busy) begin
                        ro_select <= 1'b1;  // memory goes to the readout.
                        ro_start  <= 1'b1;
                        state     <= ST_READOUT;
                    end
                end
                ST_READOUT: begin
                    if (ro_done) begin
                        ro_select  <= 1'b0;
                        frame_done <= 1'b1;
                        cur_pixel  <= '0;
                        state      <= ST_CLEAR;  // clear_done is still high, so one cycle.
                    end
                end
                default: state <= ST_CLEAR;
            endcase
        end
    end

endmodule

/* source/bin_accumulator.sv */
`timescale 1ns/1ps
`include "hist_settings.svh"

module bin_accumulator (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      hit_valid,
    input  hist_pkg::event_word_t     ev_word,
    input  logic [`HIST_PIX_BITS-1:0] cur_pixel,
    output logic                      acc_busy,
    bin_mem_if.client                 mem
);
    import hist_pkg::*;

    logic       hit_take;
    bin_addr_t  hit_addr;

    logic       s1_valid;   // read issued, data arrives this cycle.
    bin_addr_t  s1_addr;
    logic       s2_valid;   // new count, written at the next edge.
    bin_addr_t  s2_addr;
    bin_count_t s2_count;
    logic       s3_valid;   // write that landed at the edge s1 was read.
    bin_addr_t  s3_addr;
    bin_count_t s3_count;

    bin_count_t base;
    bin_count_t next_count;

    assign hit_take = hit_valid && (ev_word.hit.kind == EV_HIT);
    assign hit_addr = {cur_pixel, ev_word.hit.bin};

    assign mem.rd_en   = hit_take;
    assign mem.rd_addr = hit_addr;

    // the memory returns the old count on a collision, so take the newest one in flight.
    always_comb begin
        if (s2_valid && (s2_addr == s1_addr)) begin
            base = s2_count;
        end else if (s3_valid && (s3_addr == s1_addr)) begin
            base = s3_count;
        end else begin
            base = mem.rd_data;
        end
        next_count = (base == '1) ? base : base + 1'b1;  // holds at max.
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            s1_valid <= hit_take;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr  <= hit_addr;
        s2_addr  <= s1_addr;
        s2_count <= next_count;
        s3_addr  <= s2_addr;
        s3_count <= s2_count;
    end

    assign mem.wr_en   = s2_valid;
    assign mem.wr_addr = s2_addr;
    assign mem.wr_data = s2_count;

    assign acc_busy = s1_valid | s2_valid;

endmodule

/* source/bin_memory.sv */
`timescale 1ns/1ps
`include "hist_settings.svh"

module bin_memory (
    input  logic       clk,
    input  logic       res,
    input  logic       ro_select,
    bin_mem_if.memory  acc,
    bin_mem_if.memory  ro,
    output logic       clear_done
);
    import hist_pkg::*;

    bin_count_t ram [0:(1 << `HIST_ADDR_W)-1];

    logic                    clearing;
    logic [`HIST_ADDR_W-1:0] clr_addr;

    logic       rd_en;
    bin_addr_t  rd_addr;
    bin_count_t rd_q;
    logic       wr_en;
    bin_addr_t  wr_addr;
    bin_count_t wr_data;

    always_comb begin
        if (ro_select) begin
            rd_en   = ro.rd_en;
            rd_addr = ro.rd_addr;
            wr_en   = ro.wr_en;
            wr_addr = ro.wr_addr;
            wr_data = ro.wr_data;
        end else begin
            rd_en   = acc.rd_en;
            rd_addr = acc.rd_addr;
            wr_en   = acc.wr_en;
            wr_addr = acc.wr_addr;
            wr_data = acc.wr_data;
        end
    end

    // one address per cycle after reset.
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clearing   <= 1'b1;
            clr_addr   <= '0;
            clear_done <= 1'b0;
        end else if (clearing) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == '1) begin
                clearing   <= 1'b0;
                clear_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clearing) begin
            ram[clr_addr] <= '0;
        end else if (wr_en) begin
            ram[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_q <= ram[rd_addr];  // old data on a same-address write.
        end
    end

    assign acc.rd_data = rd_q;
    assign ro.rd_data  = rd_q;

endmodule

/* source/hist_readout.sv */
`timescale 1ns/1ps
`include "hist_settings.svh"

module hist_readout (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      ro_start,
    input  logic                      credit_return,
    bin_mem_if.client                 mem,
    output logic                      rd_valid,
    output logic [`HIST_PIX_BITS-1:0] rd_pixel,
    output logic [`HIST_BIN_BITS-1:0] rd_bin,
    output hist_pkg::bin_count_t      rd_count,
    output logic                      ro_done
);
    import hist_pkg::*;

    logic                                 active;
    logic [`HIST_ADDR_W-1:0]              addr;
    logic [$clog2(`HIST_CREDITS + 1)-1:0] credits;
    logic                                 issue;
    logic                                 s_valid;  // read data arrives this cycle.
    bin_addr_t                            s_addr;

    // a credit is spent at the read, so words in flight are covered too.
    assign issue = active && (credits != '0);

    assign mem.rd_en   = issue;
    assign mem.rd_addr = addr;
    assign mem.wr_en   = s_valid;  // zero lands with rd_valid.
    assign mem.wr_addr = s_addr;
    assign mem.wr_data = '0;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active   <= 1'b0;
            addr     <= '0;
            credits  <= `HIST_CREDITS;
            s_valid  <= 1'b0;
            rd_valid <= 1'b0;
            ro_done  <= 1'b0;
        end else begin
            if (ro_start) begin
                active <= 1'b1;
                addr   <= '0;
            end else if (issue) begin
                addr <= addr + 1'b1;
                if (addr == '1) begin
                    active <= 1'b0;  // last bin of the last pixel.
                end
            end
            credits  <= credits - issue + credit_return;
            s_valid  <= issue;
            rd_valid <= s_valid;
            ro_done  <= s_valid && (s_addr == '1);
        end
    end

    always_ff @(posedge clk) begin
        s_addr <= addr;
        if (s_valid) begin
            rd_count <= mem.rd_data;
            rd_pixel <= s_addr.pixel;
            rd_bin   <= s_addr.bin;
        end
    end

endmodule

/* source/hist_top.sv */
`timescale 1ns/1ps
`include "hist_settings.svh"

module hist_top (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      ev_valid,
    input  hist_pkg::event_word_t     ev_word,
    output logic                      accepting,
    output logic                      rd_valid,
    output logic [`HIST_PIX_BITS-1:0] rd_pixel,
    output logic [`HIST_BIN_BITS-1:0] rd_bin,
    output hist_pkg::bin_count_t      rd_count,
    input  logic                      credit_return,
    output logic                      frame_done
);

    logic                      hit_valid;
    logic                      clear_done;
    logic                      acc_busy;
    logic                      ro_select;
    logic                      ro_start;
    logic                      ro_done;
    logic [`HIST_PIX_BITS-1:0] cur_pixel;

    bin_mem_if acc_port ();
    bin_mem_if ro_port ();

    assign hit_valid = ev_valid & accepting;  // no back-pressure, late events drop.

    hist_ctrl i_hist_ctrl (
        .clk        (clk),
        .res        (res),
        .ev_valid   (ev_valid),
        .ev_word    (ev_word),
        .clear_done (clear_done),
        .acc_busy   (acc_busy),
        .ro_done    (ro_done),
        .accepting  (accepting),
        .cur_pixel  (cur_pixel),
        .ro_select  (ro_select),
        .ro_start   (ro_start),
        .frame_done (frame_done)
    );

    bin_accumulator i_bin_accumulator (
        .clk       (clk),
        .res       (res),
        .hit_valid (hit_valid),
        .ev_word   (ev_word),
        .cur_pixel (cur_pixel),
        .acc_busy  (acc_busy),
        .mem       (acc_port.client)
    );

    bin_memory i_bin_memory (
        .clk        (clk),
        .res        (res),
        .ro_select  (ro_select),
        .acc        (acc_port.memory),
        .ro         (ro_port.memory),
        .clear_done (clear_done)
    );

    hist_readout i_hist_readout (
        .clk           (clk),
        .res           (res),
        .ro_start      (ro_start),
        .credit_return (credit_return),
        .mem           (ro_port.client),
        .rd_valid      (rd_valid),
        .rd_pixel      (rd_pixel),
        .rd_bin        (rd_bin),
        .rd_count      (rd_count),
        .ro_done       (ro_done)
    );

endmodule

/* dv/tb_hist_top.sv */
`timescale 1ns/1ps
`include "hist_settings.svh"

module tb_hist_top;
    import hist_pkg::*;

    localparam int NBINS     = 1 << `HIST_ADDR_W;
    localparam int MAX_HITS  = 7;    // random hits per pixel and acquisition.
    localparam int MAX_GAP   = 3;    // idle cycles between credit returns.
    localparam int FRAMES    = 2;
    localparam int EV_FRAME  = `HIST_ACQS * (4 * (1 + MAX_HITS) + 1) + 100 + 30;
    localparam int LIMIT     = NBINS + 10 + FRAMES * (EV_FRAME + NBINS * (MAX_GAP + 2) + 40) + 300;

    logic                      clk;
    logic                      res;
    logic                      ev_valid;
    event_word_t               ev_word;
    logic                      accepting;
    logic                      rd_valid;
    logic [`HIST_PIX_BITS-1:0] rd_pixel;
    logic [`HIST_BIN_BITS-1:0] rd_bin;
    bin_count_t                rd_count;
    logic                      credit_return;
    logic                      frame_done;

    bin_count_t  model [0:NBINS-1];  // expected counts of the running frame.
    logic [15:0] lfsr;
    int          cur_pix;
    int          val_errs;
    int          other_errs;
    int          words_got;          // rd_valid pulses seen.
    int          returned;           // credit_return cycles driven.
    int          words_in_frame;
    int          frames_seen;
    int          rel_cycles;         // edges since reset release.
    int          cycles;
    logic        ret_enable;
    int          gap;

    hist_top i_hist_top (
        .clk           (clk),
        .res           (res),
        .ev_valid      (ev_valid),
        .ev_word       (ev_word),
        .accepting     (accepting),
        .rd_valid      (rd_valid),
        .rd_pixel      (rd_pixel),
        .rd_bin        (rd_bin),
        .rd_count      (rd_count),
        .credit_return (credit_return),
        .frame_done    (frame_done)
    );

    always #50 clk = ~clk;

    // taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = (r << 1) | lfsr[0];
        end
        return r;
    endfunction

    task automatic send_hit(input int b);
        event_word_t w;
        int          a;
        w = '0;
        w.hit.kind = EV_HIT;
        w.hit.bin = b[`HIST_BIN_BITS-1:0];
        @(posedge clk);
        #5;
        ev_valid = 1'b1;
        ev_word = w;
        if (accepting) begin
            a = (cur_pix << `HIST_BIN_BITS) | b;
            if (model[a] != '1) model[a] = model[a] + 1'b1;  // saturates.
        end
    endtask

    task automatic send_marker(input int pix, input logic eoa);
        event_word_t w;
        w = '0;
        w.marker.kind = EV_MARKER;
        w.marker.eoa = eoa;
        w.marker.pixel = pix[`HIST_PIX_BITS-1:0];
        @(posedge clk);
        #5;
        ev_valid = 1'b1;
        ev_word = w;
        if (accepting) cur_pix = pix;
    endtask

    task automatic idle();
        @(posedge clk);
        #5;
        ev_valid = 1'b0;
    endtask

    // random hits over all pixels and a burst on one bin.
    // the last acquisition stays open for the caller.
    task automatic run_frame(input int burst_pix, input int burst_bin, input int burst_len);
        while (!accepting) @(posedge clk);
        for (int acq = 0; acq < `HIST_ACQS; acq++) begin
            for (int p = 0; p < 4; p++) begin
                send_marker(p, 1'b0);
                for (int h = rand_bits(3); h > 0; h--) send_hit(rand_bits(`HIST_BIN_BITS));
                if (acq == 0 && p == burst_pix) begin
                    for (int k = 0; k < burst_len; k++) send_hit(burst_bin);
                end
            end
            if (acq < `HIST_ACQS - 1) send_marker(0, 1'b1);
        end
    endtask

    // the final end marker drops accepting at the edge that takes it.
    task automatic close_frame(input int pix);
        send_marker(pix, 1'b1);
        assert (accepting) else begin
            val_errs++;
            $display("** Error: %0t accepting low before the last marker", $time);
        end
        idle();
        assert (!accepting) else begin
            val_errs++;
            $display("** Error: %0t accepting still high after the last marker", $time);
        end
    endtask

    // consumer side, returns credits after random gaps.
    always @(posedge clk) begin
        #5;
        credit_return = 1'b0;
        if (ret_enable && (words_got - returned) > 0) begin
            if (gap == 0) begin
                credit_return = 1'b1;
                returned = returned + 1;
                gap = rand_bits(2);
            end else begin
                gap = gap - 1;
            end
        end
    end

    always @(negedge clk) begin
        if (!res) begin
            assert (!accepting && !rd_valid && !frame_done) else begin
                val_errs++;
                $display("** Error: %0t outputs not low in reset", $time);
            end
        end else if (frames_seen == 0 && rel_cycles <= NBINS + 1) begin
            assert (accepting == (rel_cycles == NBINS + 1)) else begin
                val_errs++;
                $display("** Error: %0t accepting=%0b at cycle %0d of clear sweep",
                         $time, accepting, rel_cycles);
            end
        end
        if (rd_valid) begin
            assert ({rd_pixel, rd_bin} == words_in_frame[`HIST_ADDR_W-1:0]) else begin
                val_errs++;
                $display("** Error: %0t word %0d has address %0d/%0d",
                         $time, words_in_frame, rd_pixel, rd_bin);
            end
            assert (rd_count == model[words_in_frame % NBINS]) else begin
                val_errs++;
                $display("** Error: %0t bin %0d count %0d, expected %0d", $time,
                         words_in_frame, rd_count, model[words_in_frame % NBINS]);
            end
            model[words_in_frame % NBINS] = '0;  // clear on read.
            words_in_frame++;
            words_got++;
        end
        if (frame_done) begin
            assert (words_in_frame == NBINS) else begin
                val_errs++;
                $display("** Error: %0t frame_done after %0d words", $time, words_in_frame);
            end
            words_in_frame = 0;
            frames_seen++;
        end
    end

    assert property (@(posedge clk) disable iff (!res) (words_got - returned) <= `HIST_CREDITS)
        else begin
            other_errs++;
            $display("more words outstanding than credits at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (!res) !(rd_valid && frame_done))
        else begin
            other_errs++;
            $display("frame_done came together with a word at %0t", $time);
        end

    always @(posedge clk) begin
        cycles++;
        if (res) rel_cycles++;
        if (cycles > LIMIT) begin
            $display("run did not finish within %0d cycles", LIMIT);
            $display("errors: %0d value, %0d other", val_errs, other_errs + 1);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        res = 1'b0;
        ev_valid = 1'b0;
        ev_word = '0;
        credit_return = 1'b0;
        lfsr = 16'd20;
        cur_pix = 0;
        val_errs = 0;
        other_errs = 0;
        words_got = 0;
        returned = 0;
        words_in_frame = 0;
        frames_seen = 0;
        rel_cycles = 0;
        cycles = 0;
        ret_enable = 1'b0;
        gap = 0;
        for (int i = 0; i < NBINS; i++) model[i] = '0;
        repeat (4) @(posedge clk);
        #5;
        res = 1'b1;

        run_frame(1, 5, 20);
        for (int k = 0; k < 70; k++) send_hit(9);  // pixel 3 bin 9 ends at max.
        close_frame(2);
        // dropped while the frame drains and reads out.
        for (int k = 0; k < 30; k++) begin
            if (k % 5 == 0) send_marker(rand_bits(2), 1'b0);
            else send_hit(rand_bits(`HIST_BIN_BITS));
        end
        idle();
        while (words_got < `HIST_CREDITS) @(posedge clk);
        repeat (10) @(posedge clk);
        assert (words_got == `HIST_CREDITS) else begin
            val_errs++;
            $display("** Error: %0t %0d words without a credit return", $time, words_got);
        end
        ret_enable = 1'b1;
        while (frames_seen < 1) @(posedge clk);
        cur_pix = 0;

        run_frame(3, 2, 12);
        close_frame(0);
        while (frames_seen < FRAMES) @(posedge clk);
        repeat (5) @(posedge clk);

        $display("errors: %0d value, %0d other", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+source
source/hist_pkg.sv
source/bin_mem_if.sv
source/hist_ctrl.sv
source/bin_accumulator.sv
source/bin_memory.sv
source/hist_readout.sv
source/hist_top.sv
dv/tb_hist_top.sv
